// ==== logic/uart_pkg.sv ====
package uart_pkg;

    localparam int DATA_BITS = 8;

    // Frame sequencing shared by the receiver and the transmitter
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        START = 2'b01,
        DATA  = 2'b10,
        STOP  = 2'b11
    } uart_state_t;

    typedef enum logic {
        REG_DATA   = 1'b0,
        REG_STATUS = 1'b1
    } uart_reg_t;

    // Bit positions in the status register
    localparam int STAT_TX_READY  = 0;
    localparam int STAT_RX_VALID  = 1;
    localparam int STAT_OVERRUN   = 2;
    localparam int STAT_FRAME_ERR = 3;

endpackage

// ==== logic/uart_byte_if.sv ====
interface uart_byte_if;
    import uart_pkg::*;

    logic                 transmit;   // One-cycle request from the register block
    logic [DATA_BITS-1:0] tx_byte;
    logic                 tx_ready;   // High while the transmitter is idle
    logic                 received;
    logic [DATA_BITS-1:0] rx_byte;
    logic                 frame_err;  // Stop bit sampled low

    modport regs (
        output transmit,
        output tx_byte,
        input  tx_ready,
        input  received,
        input  rx_byte,
        input  frame_err
    );

    modport core (
        input  transmit,
        input  tx_byte,
        output tx_ready,
        output received,
        output rx_byte,
        output frame_err
    );

endinterface

// ==== logic/uart_rx.sv ====
module uart_rx #(
    parameter int CLK_FREQ  = 36000000,
    parameter int BAUD_RATE = 9600
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    uart_byte_if.core  byte_bus
);
    import uart_pkg::*;

    localparam int CLK_DIV = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W   = $clog2(CLK_DIV + 1);
    localparam int BIT_W   = $clog2(DATA_BITS);

    uart_state_t          state;
    logic [CNT_W-1:0]     clk_cnt;
    logic [BIT_W-1:0]     bit_idx;
    logic [DATA_BITS-1:0] shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            state              <= IDLE;
            clk_cnt            <= '0;
            bit_idx            <= '0;
            byte_bus.received  <= 1'b0;
            byte_bus.frame_err <= 1'b0;
        end else begin
            byte_bus.received  <= 1'b0;
            byte_bus.frame_err <= 1'b0;

            if (clk_cnt != '0)
                clk_cnt <= clk_cnt - 1'b1;

            case (state)
                IDLE: begin
                    // Falling edge of a start bit, wait half a bit to reach its middle
                    if (!rx) begin
                        state   <= START;
                        clk_cnt <= CNT_W'(CLK_DIV / 2 - 1);
                    end
                end
                START: begin
                    if (clk_cnt == '0) begin
                        if (!rx) begin
                            state   <= DATA;
                            clk_cnt <= CNT_W'(CLK_DIV - 1);
                            bit_idx <= '0;
                        end else begin
                            state <= IDLE; // Line went high again, treat it as a glitch
                        end
                    end
                end
                DATA: begin
                    if (clk_cnt == '0) begin
                        shift   <= {rx, shift[DATA_BITS-1:1]}; // LSB arrives first
                        clk_cnt <= CNT_W'(CLK_DIV - 1);
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == BIT_W'(DATA_BITS - 1))
                            state <= STOP;
                    end
                end
                STOP: begin
                    if (clk_cnt == '0) begin
                        state <= IDLE;
                        if (rx) begin
                            byte_bus.received <= 1'b1;
                            byte_bus.rx_byte  <= shift;
                        end else begin
                            byte_bus.frame_err <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== logic/uart_tx.sv ====
module uart_tx #(
    parameter int CLK_FREQ  = 36000000,
    parameter int BAUD_RATE = 9600
) (
    input  logic       clk,
    input  logic       reset,
    output logic       tx,
    uart_byte_if.core  byte_bus
);
    import uart_pkg::*;

    localparam int CLK_DIV = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W   = $clog2(CLK_DIV + 1);
    localparam int BIT_W   = $clog2(DATA_BITS);

    uart_state_t          state;
    logic [CNT_W-1:0]     clk_cnt;
    logic [BIT_W-1:0]     bit_idx;
    logic [DATA_BITS-1:0] shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            state             <= IDLE;
            clk_cnt           <= '0;
            bit_idx           <= '0;
            tx                <= 1'b1;
            byte_bus.tx_ready <= 1'b1;
        end else begin
            if (clk_cnt != '0)
                clk_cnt <= clk_cnt - 1'b1;

            case (state)
                IDLE: begin
                    if (byte_bus.transmit) begin
                        state             <= START;
                        clk_cnt           <= CNT_W'(CLK_DIV - 1);
                        shift             <= byte_bus.tx_byte;
                        tx                <= 1'b0; // Start bit
                        byte_bus.tx_ready <= 1'b0;
                    end
                end
                START: begin
                    if (clk_cnt == '0) begin
                        state   <= DATA;
                        clk_cnt <= CNT_W'(CLK_DIV - 1);
                        bit_idx <= '0;
                        tx      <= shift[0];
                        shift   <= shift >> 1;
                    end
                end
                DATA: begin
                    if (clk_cnt == '0) begin
                        clk_cnt <= CNT_W'(CLK_DIV - 1);
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == BIT_W'(DATA_BITS - 1)) begin
                            state <= STOP;
                            tx    <= 1'b1;
                        end else begin
                            tx    <= shift[0];
                            shift <= shift >> 1;
                        end
                    end
                end
                STOP: begin
                    // Ready again only once the whole stop bit has been on the line
                    if (clk_cnt == '0) begin
                        state             <= IDLE;
                        byte_bus.tx_ready <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== logic/uart_regs.sv ====
module uart_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                sel,
    input  logic                write,
    input  uart_pkg::uart_reg_t addr,
    input  logic [7:0]          write_data,
    output logic [7:0]          read_data,
    uart_byte_if.regs           byte_bus
);
    import uart_pkg::*;

    logic                 rx_valid;
    logic                 overrun;
    logic                 frame_err;
    logic [DATA_BITS-1:0] rx_data;
    logic [7:0]           status;

    logic data_write;
    logic data_read;
    logic status_read;
    logic tx_accept;

    assign data_write  = sel && write && (addr == REG_DATA);
    assign data_read   = sel && !write && (addr == REG_DATA);
    assign status_read = sel && !write && (addr == REG_STATUS);

    // A request still in flight has not yet dropped tx_ready, so it blocks a second one
    assign tx_accept = data_write && byte_bus.tx_ready && !byte_bus.transmit;

    always_comb begin
        status                 = '0;
        status[STAT_TX_READY]  = byte_bus.tx_ready;
        status[STAT_RX_VALID]  = rx_valid;
        status[STAT_OVERRUN]   = overrun;
        status[STAT_FRAME_ERR] = frame_err;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_bus.transmit <= 1'b0;
            rx_valid          <= 1'b0;
            overrun           <= 1'b0;
            frame_err         <= 1'b0;
            read_data         <= '0;
        end else begin
            byte_bus.transmit <= tx_accept;
            if (tx_accept)
                byte_bus.tx_byte <= write_data;

            if (data_read) begin
                read_data <= rx_data;
                rx_valid  <= 1'b0;
                overrun   <= 1'b0;
            end else if (status_read) begin
                read_data <= status;
                frame_err <= 1'b0;
            end

            // New byte wins over a clear in the same cycle
            if (byte_bus.received) begin
                rx_data  <= byte_bus.rx_byte;
                rx_valid <= 1'b1;
                if (rx_valid && !data_read)
                    overrun <= 1'b1; // Held byte was never read
            end

            if (byte_bus.frame_err)
                frame_err <= 1'b1;
        end
    end

endmodule

// ==== logic/uart_top.sv ====
module uart_top #(
    parameter int CLK_FREQ  = 36000000,
    parameter int BAUD_RATE = 9600
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                sel,
    input  logic                write,
    input  uart_pkg::uart_reg_t addr,
    input  logic [7:0]          write_data,
    output logic [7:0]          read_data,
    input  logic                rx,
    output logic                tx
);

    uart_byte_if byte_bus ();

    uart_regs regs_i (
        .clk        (clk),
        .reset      (reset),
        .sel        (sel),
        .write      (write),
        .addr       (addr),
        .write_data (write_data),
        .read_data  (read_data),
        .byte_bus   (byte_bus.regs)
    );

    uart_rx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) rx_i (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .byte_bus (byte_bus.core)
    );

    uart_tx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) tx_i (
        .clk      (clk),
        .reset    (reset),
        .tx       (tx),
        .byte_bus (byte_bus.core)
    );

endmodule

// ==== tb/uart_checker.sv ====
module uart_checker (
    input logic clk,
    input logic reset,
    input logic tx,
    input logic transmit,
    input logic tx_ready,
    input logic received,
    input logic frame_err
);

    int violation_count = 0;

    transmit_only_when_ready: assert property (
        @(posedge clk) disable iff (reset) transmit |-> tx_ready
    ) else begin
        $error("transmit pulsed while the transmitter was busy");
        violation_count++;
    end

    // A frame ends either good or bad, never both
    received_xor_frame_err: assert property (
        @(posedge clk) disable iff (reset) !(received && frame_err)
    ) else begin
        $error("received and frame_err high in the same cycle");
        violation_count++;
    end

    line_idle_when_ready: assert property (
        @(posedge clk) disable iff (reset) tx_ready |-> tx
    ) else begin
        $error("tx low while the transmitter reports ready");
        violation_count++;
    end

endmodule

bind uart_top uart_checker checker_i (
    .clk       (clk),
    .reset     (reset),
    .tx        (tx),
    .transmit  (byte_bus.transmit),
    .tx_ready  (byte_bus.tx_ready),
    .received  (byte_bus.received),
    .frame_err (byte_bus.frame_err)
);

// ==== tb/uart_tb.sv ====
module uart_tb;
    import uart_pkg::*;

    localparam int BIT_CYCLES   = 16;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_COUNT = 4;

    logic       clk;
    logic       reset;
    logic       sel;
    logic       write;
    uart_reg_t  addr;
    logic [7:0] write_data;
    logic [7:0] read_data;
    logic       rx;
    logic       tx;

    logic [95:0] op_q[$];   // Opcode text, right aligned as $fscanf stores it
    logic [7:0]  byte_q[$];
    logic [7:0]  exp_q[$];

    int     error_count = 0;
    int     check_count = 0;
    int     cycle_count = 0;
    int     cycle_limit = 200000;
    integer seed;

    uart_top #(
        .CLK_FREQ  (16),
        .BAUD_RATE (1)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .sel        (sel),
        .write      (write),
        .addr       (addr),
        .write_data (write_data),
        .read_data  (read_data),
        .rx         (rx),
        .tx         (tx)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("test failed");
        $finish;
    end

    task automatic check_value(input string what, input logic [7:0] expected,
                               input logic [7:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s expected %02h, got %02h", $time, what, expected, actual);
        end
    endtask

    task automatic load_patterns(input int fd);
        logic [95:0] tok;
        logic [7:0]  b;
        logic [7:0]  e;
        int          r;
        int          ch;
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", tok);
            if (r == 1) begin
                if (tok == "#") begin
                    ch = $fgetc(fd);
                    while (ch != "\n" && ch != -1)
                        ch = $fgetc(fd);
                end else begin
                    r = $fscanf(fd, "%h %h", b, e);
                    op_q.push_back(tok);
                    byte_q.push_back(b);
                    exp_q.push_back(e);
                end
            end
        end
    endtask

    task automatic bus_write(input uart_reg_t a, input logic [7:0] d);
        @(posedge clk);
        sel        <= 1'b1;
        write      <= 1'b1;
        addr       <= a;
        write_data <= d;
        @(posedge clk);
        sel   <= 1'b0;
        write <= 1'b0;
    endtask

    task automatic bus_read(input uart_reg_t a, output logic [7:0] d);
        @(posedge clk);
        sel   <= 1'b1;
        write <= 1'b0;
        addr  <= a;
        @(posedge clk);
        sel <= 1'b0;
        @(negedge clk);
        d = read_data; // Registered, so valid the cycle after the access
    endtask

    // Start bit, 8 data bits LSB first, stop bit, then one idle bit time
    task automatic send_frame(input logic [7:0] b, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (BIT_CYCLES - 1) @(posedge clk);
        end
        @(posedge clk);
        rx <= 1'b1;
        repeat (BIT_CYCLES - 1) @(posedge clk);
    endtask

    task automatic send_glitch();
        @(posedge clk);
        rx <= 1'b0;
        repeat (BIT_CYCLES / 4) @(posedge clk); // Well short of the mid-bit point
        rx <= 1'b1;
        repeat (2 * BIT_CYCLES) @(posedge clk);
    endtask

    task automatic capture_tx(output logic [7:0] b);
        @(negedge clk);
        while (tx !== 1'b0)
            @(negedge clk);
        repeat (BIT_CYCLES / 2) @(negedge clk);
        check_value("tx start bit", 8'h00, {7'b0, tx});
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            b[i] = tx;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        check_value("tx stop bit", 8'h01, {7'b0, tx});
    endtask

    task automatic run_transmit(input logic [7:0] b, input logic [7:0] expected);
        logic [7:0] seen;
        logic [7:0] status;
        logic       idle_ok;
        idle_ok = 1'b1;
        bus_write(REG_DATA, b);
        fork
            capture_tx(seen);
            begin
                repeat (2 * BIT_CYCLES) @(posedge clk);
                bus_read(REG_STATUS, status);
                check_value("tx_ready during frame", 8'h00, {7'b0, status[STAT_TX_READY]});
                bus_write(REG_DATA, ~b); // Transmitter is busy, this byte must be dropped
            end
        join
        check_value("byte on tx", expected, seen);
        repeat (BIT_CYCLES) @(posedge clk);
        bus_read(REG_STATUS, status);
        check_value("tx_ready after frame", 8'h01, {7'b0, status[STAT_TX_READY]});
        // A second frame would show up here if the busy write had been taken
        repeat (3 * BIT_CYCLES) begin
            @(negedge clk);
            if (idle_ok && tx !== 1'b1) begin
                idle_ok = 1'b0;
                error_count++;
                $display("[ERROR] %0t: tx left idle after the frame of %02h", $time, b);
            end
        end
    endtask

    task automatic run_receive(input logic [7:0] b);
        logic [7:0] v;
        send_frame(b, 1'b1);
        bus_read(REG_STATUS, v);
        check_value("status after receive", 8'h03, v);
        bus_read(REG_DATA, v);
        check_value("received byte", b, v);
        bus_read(REG_STATUS, v);
        check_value("status after data read", 8'h01, v);
    endtask

    initial begin
        int         fd;
        logic [7:0] v;
        logic [7:0] b;
        seed       = 53437;
        reset      = 1'b1;
        sel        = 1'b0;
        write      = 1'b0;
        addr       = REG_DATA;
        write_data = 8'h00;
        rx         = 1'b1;

        fd = $fopen("tb/uart_patterns.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open tb/uart_patterns.txt");
        end else begin
            load_patterns(fd);
            $fclose(fd);
            cycle_limit = (op_q.size() + RANDOM_COUNT) * 12 * BIT_CYCLES + 1000;

            repeat (RESET_CYCLES) @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            check_value("read_data after reset", 8'h00, read_data);
            check_value("tx after reset", 8'h01, {7'b0, tx});

            foreach (op_q[i]) begin
                case (op_q[i])
                    "TX":     run_transmit(byte_q[i], exp_q[i]);
                    "RX":     send_frame(byte_q[i], 1'b1);
                    "RXBAD":  send_frame(byte_q[i], 1'b0);
                    "GLITCH": send_glitch();
                    "READ_STATUS": begin
                        bus_read(REG_STATUS, v);
                        check_value("status register", exp_q[i], v);
                    end
                    "READ_DATA": begin
                        bus_read(REG_DATA, v);
                        check_value("data register", exp_q[i], v);
                    end
                    default: begin
                        error_count++;
                        $display("Unknown opcode %0s on pattern %0d", op_q[i], i);
                    end
                endcase
            end

            // Extra bytes alternate between the two directions
            for (int i = 0; i < RANDOM_COUNT; i++) begin
                b = 8'($random(seed));
                if (i % 2 == 0)
                    run_transmit(b, b);
                else
                    run_receive(b);
            end
        end

        error_count += dut_i.checker_i.violation_count;
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== tb/uart_patterns.txt ====
# opcode  byte  expected   (hex; byte goes out on the bus or rx line)
# expected is the byte seen on tx for TX, the read value for READ_*, unused otherwise
READ_STATUS 00 01
TX          a5 a5
RX          5a 00
READ_STATUS 00 03
READ_DATA   00 5a
READ_STATUS 00 01
RX          11 00
RX          22 00
READ_STATUS 00 07
READ_DATA   00 22
READ_STATUS 00 01
RXBAD       77 00
READ_STATUS 00 09
READ_STATUS 00 01
RX          99 00
RXBAD       44 00
READ_STATUS 00 0b
READ_STATUS 00 03
READ_DATA   00 99
GLITCH      00 00
READ_STATUS 00 01
TX          3c 3c
TX          ff ff
TX          00 00
READ_STATUS 00 01

// ==== project.f ====
logic/uart_pkg.sv
logic/uart_byte_if.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_regs.sv
logic/uart_top.sv
tb/uart_checker.sv
tb/uart_tb.sv

// ==== Bender.yml ====
package:
  name: uart

sources:
  - logic/uart_pkg.sv
  - logic/uart_byte_if.sv
  - logic/uart_rx.sv
  - logic/uart_tx.sv
  - logic/uart_regs.sv
  - logic/uart_top.sv
  - target: test
    files:
      - tb/uart_checker.sv
      - tb/uart_tb.sv
